//--- design/bpred_pkg.sv
/*
  branch predictor shared types
  counter states, update and resolve records, prediction vector
*/

package bpred_pkg;

  // fetch group width, one counter bank per slot
  localparam int SLOTS = 4;

  // widest line field, covers up to 256 lines
  localparam int LINE_BITS = 8;

  // 2-bit saturating counter, msb is the predicted direction
  typedef enum logic [1:0] {
    strong_not_taken = 2'd0,
    weak_not_taken   = 2'd1,
    weak_taken       = 2'd2,
    strong_taken     = 2'd3
  } counter_state_e;

  // slot within the fetch group
  typedef logic [1:0] slot_t;

  // one direction bit per slot, bit k is slot k
  typedef logic [SLOTS-1:0] pred_vec_t;

  // single counter update toward the buffer
  typedef struct packed {
    logic [LINE_BITS-1:0] line;  // only low bits used by the buffer
    slot_t                slot;
    logic                 taken; // inc when set, dec otherwise
  } bp_update_t;

  // resolved branch record from execute
  typedef struct packed {
    logic [LINE_BITS-1:0] line;
    slot_t                slot;
    logic                 taken;     // actual outcome
    logic                 predicted; // direction fetch went with
  } resolve_t;

endpackage

//--- design/counter_bank.sv
/*
  counter bank for one fetch slot
  PRED_LINES saturating 2-bit counters, async read, one update port
*/

`timescale 1ns/1ps

module counter_bank #(
  parameter int PRED_LINES = 4,
  localparam int AW = (PRED_LINES > 1) ? $clog2(PRED_LINES) : 1
) (
  input  logic                      clock,
  input  logic                      rst,
  input  logic [AW-1:0]             read_line,  // fetch side
  input  logic                      write_en,   // update for this slot
  input  logic [AW-1:0]             write_line,
  input  logic                      taken,      // direction of the update
  output bpred_pkg::counter_state_e state      // counter at read_line
);

  bpred_pkg::counter_state_e counters [PRED_LINES];
  bpred_pkg::counter_state_e wr_state;  // counter being updated
  bpred_pkg::counter_state_e wr_next;

  // saturating step of one counter
  function automatic bpred_pkg::counter_state_e step(
    input bpred_pkg::counter_state_e cur,
    input logic                      inc
  );
    bpred_pkg::counter_state_e nxt;
    nxt = cur;
    case (cur)
      bpred_pkg::strong_not_taken:
        nxt = inc ? bpred_pkg::weak_not_taken : bpred_pkg::strong_not_taken;
      bpred_pkg::weak_not_taken:
        nxt = inc ? bpred_pkg::weak_taken : bpred_pkg::strong_not_taken;
      bpred_pkg::weak_taken:
        nxt = inc ? bpred_pkg::strong_taken : bpred_pkg::weak_not_taken;
      bpred_pkg::strong_taken:
        nxt = inc ? bpred_pkg::strong_taken : bpred_pkg::weak_taken;
      default:
        nxt = bpred_pkg::weak_not_taken; // unreachable with 2-bit enum
    endcase
    return nxt;
  endfunction

  assign wr_state = counters[write_line];
  assign wr_next  = step(wr_state, taken);

  // read sees the value before this edge's update
  assign state = counters[read_line];

  always_ff @(posedge clock) begin
    if (rst) begin
      // every line starts weakly not taken
      for (int i = 0; i < PRED_LINES; i++) begin
        counters[i] <= bpred_pkg::weak_not_taken;
      end
    end else if (write_en) begin
      counters[write_line] <= wr_next;
    end
  end

  // strong taken never drops below taken in one update
  assert property (@(posedge clock) disable iff (rst)
    (write_en && wr_state == bpred_pkg::strong_taken)
    |=> counters[$past(write_line)] >= bpred_pkg::weak_taken)
    else $error("counter_bank: strong_taken left the taken side");

  // mirror case, strong not taken stays on the not-taken side
  assert property (@(posedge clock) disable iff (rst)
    (write_en && wr_state == bpred_pkg::strong_not_taken)
    |=> counters[$past(write_line)] <= bpred_pkg::weak_not_taken)
    else $error("counter_bank: strong_not_taken left the not-taken side");

endmodule

//--- design/prediction_buffer.sv
/*
  prediction buffer, one counter bank per fetch slot
  steers resolve updates, registers msbs for the decoder
*/

`timescale 1ns/1ps

module prediction_buffer #(
  parameter int PRED_LINES = 4,
  localparam int AW = (PRED_LINES > 1) ? $clog2(PRED_LINES) : 1
) (
  input  logic                  clock,
  input  logic                  rst,
  input  logic                  stall,        // level, holds prediction
  input  logic [AW-1:0]         fetch_line,
  input  logic                  update_valid,
  input  bpred_pkg::bp_update_t update,
  output bpred_pkg::pred_vec_t  prediction    // registered, to decoder
);

  bpred_pkg::counter_state_e bank_state [bpred_pkg::SLOTS];
  bpred_pkg::pred_vec_t      read_bits;  // msb of each bank read
  logic [bpred_pkg::SLOTS-1:0] bank_we;  // one-hot write enable
  logic [AW-1:0]             upd_line;

  // low bits only, no tags
  assign upd_line = update.line[AW-1:0];

  for (genvar k = 0; k < bpred_pkg::SLOTS; k++) begin : g_bank
    // slot decode
    assign bank_we[k] = update_valid && (update.slot == bpred_pkg::slot_t'(k));

    counter_bank #(
      .PRED_LINES (PRED_LINES)
    ) u_bank (
      .clock      (clock),
      .rst        (rst),
      .read_line  (fetch_line),
      .write_en   (bank_we[k]),
      .write_line (upd_line),
      .taken      (update.taken),
      .state      (bank_state[k])
    );

    assign read_bits[k] = bank_state[k][1]; // taken if msb set
  end

  // no bypass, a same-edge update shows up one fetch later
  always_ff @(posedge clock) begin
    if (rst) begin
      prediction <= '0;
    end else if (!stall) begin
      prediction <= read_bits;
    end
  end

  // decoder sees a frozen vector through a stall
  assert property (@(posedge clock) disable iff (rst)
    stall |=> $stable(prediction))
    else $error("prediction_buffer: prediction moved during stall");

endmodule

//--- design/branch_resolve_unit.sv
/*
  branch resolve unit
  turns execute records into counter updates, flags and counts mispredicts
*/

`timescale 1ns/1ps

module branch_resolve_unit (
  input  logic                  clock,
  input  logic                  rst,
  input  logic                  resolve_valid,    // one-cycle strobe
  input  bpred_pkg::resolve_t   resolve,
  output logic                  update_valid,
  output bpred_pkg::bp_update_t update,
  output logic                  mispredict,       // one-cycle pulse
  output logic [15:0]           mispredict_count  // saturating
);

  logic mismatch;   // outcome differs from what fetch used
  logic count_max;  // counter pinned at all ones

  assign mismatch  = resolve_valid && (resolve.taken != resolve.predicted);
  assign count_max = &mispredict_count;

  // control side
  always_ff @(posedge clock) begin
    if (rst) begin
      update_valid <= 1'b0;
      mispredict   <= 1'b0;
    end else begin
      update_valid <= resolve_valid; // one update per record, no stall
      mispredict   <= mismatch;
    end
  end

  // payload, only meaningful with update_valid
  always_ff @(posedge clock) begin
    if (resolve_valid) begin
      update.line  <= resolve.line;
      update.slot  <= resolve.slot;
      update.taken <= resolve.taken; // counter trains on actual outcome
    end
  end

  // mispredict statistics
  always_ff @(posedge clock) begin
    if (rst) begin
      mispredict_count <= '0;
    end else if (mismatch && !count_max) begin
      mispredict_count <= mispredict_count + 16'd1; // bumps with the pulse
    end
  end

  // count only ever climbs between resets
  assert property (@(posedge clock) disable iff (rst)
    !$past(rst) |-> mispredict_count >= $past(mispredict_count))
    else $error("branch_resolve_unit: mispredict_count went down");

endmodule

//--- design/bpred_top.sv
/*
  branch direction predictor top
  resolve unit feeding the four-slot prediction buffer
*/

`timescale 1ns/1ps

module bpred_top #(
  parameter int PRED_LINES = 4,
  localparam int AW = (PRED_LINES > 1) ? $clog2(PRED_LINES) : 1
) (
  input  logic                 clock,
  input  logic                 rst,
  input  logic                 stall,
  input  logic [AW-1:0]        fetch_line,
  input  logic                 resolve_valid,
  input  bpred_pkg::resolve_t  resolve,
  output bpred_pkg::pred_vec_t prediction,
  output logic                 mispredict,
  output logic [15:0]          mispredict_count
);

  logic                  update_valid;
  bpred_pkg::bp_update_t update;

  // execute side
  branch_resolve_unit u_resolve (
    .clock            (clock),
    .rst              (rst),
    .resolve_valid    (resolve_valid),
    .resolve          (resolve),
    .update_valid     (update_valid),
    .update           (update),
    .mispredict       (mispredict),
    .mispredict_count (mispredict_count)
  );

  // fetch side
  prediction_buffer #(
    .PRED_LINES (PRED_LINES)
  ) u_buffer (
    .clock        (clock),
    .rst          (rst),
    .stall        (stall),
    .fetch_line   (fetch_line),
    .update_valid (update_valid),
    .update       (update),
    .prediction   (prediction)
  );

endmodule

//--- tests/clock_gen.sv
/*
  testbench clock and reset source
  free-running clock, synchronous reset held for a fixed number of cycles
*/

`timescale 1ns/1ps

module clock_gen #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 5
) (
  output logic clock,
  output logic rst
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  // release shortly after the last reset edge, like other stimulus
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    #1 rst = 1'b0;
  end

endmodule

//--- tests/bpred_tb.sv
/*
  testbench for the branch direction predictor
  random fetches, stalls and resolve records checked against a counter model
*/

`timescale 1ns/1ps

module bpred_tb;

  localparam int LINES         = 4;
  localparam int AW            = $clog2(LINES);
  localparam int MIX_CYCLES    = 4000;
  localparam int RESET_TIMEOUT = 50;  // edges allowed before reset drops

  logic                 clock;
  logic                 rst;
  logic                 stall;
  logic [AW-1:0]        fetch_line;
  logic                 resolve_valid;
  bpred_pkg::resolve_t  resolve;
  bpred_pkg::pred_vec_t prediction;
  logic                 mispredict;
  logic [15:0]          mispredict_count;

  // reference model counters held as 0 (strong nt) .. 3 (strong t)
  int                   m_ctr [LINES][bpred_pkg::SLOTS];
  bpred_pkg::pred_vec_t m_pred;        // model prediction register
  logic                 m_upd_valid;   // registered record in flight
  int                   m_upd_line;
  int                   m_upd_slot;
  logic                 m_upd_taken;
  logic                 m_mispredict;
  int                   m_count;

  int   errors;
  int   checks;
  logic rst_at_edge;  // rst as sampled by the last edge

  clock_gen #(
    .PERIOD       (8),
    .RESET_CYCLES (5)
  ) clk_i (
    .clock (clock),
    .rst   (rst)
  );

  bpred_top #(
    .PRED_LINES (LINES)
  ) dut_i (
    .clock            (clock),
    .rst              (rst),
    .stall            (stall),
    .fetch_line       (fetch_line),
    .resolve_valid    (resolve_valid),
    .resolve          (resolve),
    .prediction       (prediction),
    .mispredict       (mispredict),
    .mispredict_count (mispredict_count)
  );

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
    end
  endtask

  // all counters weakly not taken and pipeline empty
  task automatic model_reset();
    for (int l = 0; l < LINES; l++) begin
      for (int k = 0; k < bpred_pkg::SLOTS; k++) begin
        m_ctr[l][k] = 1;
      end
    end
    m_pred       = '0;
    m_upd_valid  = 1'b0;
    m_upd_line   = 0;
    m_upd_slot   = 0;
    m_upd_taken  = 1'b0;
    m_mispredict = 1'b0;
    m_count      = 0;
  endtask

  // one rising edge of the model on the inputs the DUT samples
  task automatic model_edge();
    if (rst) begin
      model_reset();
    end else begin
      if (!stall) begin
        for (int k = 0; k < bpred_pkg::SLOTS; k++) begin
          m_pred[k] = (m_ctr[fetch_line][k] >= 2); // read before the update
        end
      end
      if (m_upd_valid) begin
        if (m_upd_taken && m_ctr[m_upd_line][m_upd_slot] < 3) begin
          m_ctr[m_upd_line][m_upd_slot]++;
        end else if (!m_upd_taken && m_ctr[m_upd_line][m_upd_slot] > 0) begin
          m_ctr[m_upd_line][m_upd_slot]--;
        end
      end
      m_upd_valid  = resolve_valid;
      m_upd_line   = int'(resolve.line) % LINES;  // low bits index the line
      m_upd_slot   = int'(resolve.slot);
      m_upd_taken  = resolve.taken;
      m_mispredict = resolve_valid && (resolve.taken != resolve.predicted);
      if (m_mispredict && m_count < 65535) begin
        m_count++;  // saturates at the 16-bit maximum
      end
    end
  endtask

  // advance one clock and compare once outputs have settled
  task automatic step_cycle();
    @(posedge clock);
    rst_at_edge = rst;
    model_edge();
    #1;
    check_value("prediction", 32'(m_pred), 32'(prediction));
    check_value("mispredict", 32'(m_mispredict), 32'(mispredict));
    check_value("mispredict_count", 32'(m_count), 32'(mispredict_count));
  endtask

  task automatic wait_reset(output logic ok);
    int n;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < RESET_TIMEOUT) begin
      step_cycle();
      n++;
      if (!rst_at_edge) begin
        ok = 1'b1;
      end
    end
  endtask

  task automatic drive_record(input int line, input int slot, input logic taken,
                              input logic predicted);
    resolve_valid       = 1'b1;
    resolve.line        = 8'(line);
    resolve.slot        = bpred_pkg::slot_t'(slot);
    resolve.taken       = taken;
    resolve.predicted   = predicted;
  endtask

  // random record with the strobe set about half the time
  task automatic drive_random_record();
    resolve_valid     = 1'($urandom_range(1));
    resolve.line      = 8'($urandom_range(255));  // upper bits must be ignored
    resolve.slot      = bpred_pkg::slot_t'($urandom_range(bpred_pkg::SLOTS - 1));
    resolve.taken     = 1'($urandom_range(1));
    resolve.predicted = 1'($urandom_range(1));
  endtask

  task automatic zero_after_reset();
    stall         = 1'b0;
    resolve_valid = 1'b0;
    for (int l = 0; l < LINES; l++) begin
      fetch_line = AW'(l);
      step_cycle();
      check_value("prediction", 32'd0, 32'(prediction));  // weak nt everywhere
    end
  endtask

  // idle until a record sent at the last edge shows up in prediction
  task automatic read_back(input int line, input int slot, input logic expected);
    resolve_valid = 1'b0;
    stall         = 1'b0;
    fetch_line    = AW'(line);
    repeat (2) step_cycle();  // update lands at n+1 and is read at n+2
    check_value("prediction slot bit", 32'(expected), 32'(prediction[slot]));
  endtask

  task automatic saturation_run(input int line, input int slot, input logic dir);
    stall = 1'b0;
    for (int i = 0; i < 6; i++) begin
      drive_record(line, slot, dir, 1'($urandom_range(1)));
      step_cycle();
    end
    read_back(line, slot, dir);
    // one opposite outcome only weakens the counter
    drive_record(line, slot, !dir, 1'($urandom_range(1)));
    step_cycle();
    read_back(line, slot, dir);
  endtask

  task automatic stall_hold_run(input int stretches);
    bpred_pkg::pred_vec_t held;
    int                   len;
    for (int s = 0; s < stretches; s++) begin
      held  = m_pred;   // value when stall rises
      stall = 1'b1;
      len   = 1 + int'($urandom_range(9));
      for (int i = 0; i < len; i++) begin
        fetch_line = AW'($urandom_range(LINES - 1));
        drive_random_record();  // counters keep training
        step_cycle();
        check_value("prediction", 32'(held), 32'(prediction));
      end
      stall         = 1'b0;
      resolve_valid = 1'b0;
      repeat (1 + int'($urandom_range(3))) step_cycle();
    end
  endtask

  task automatic mispredict_run(input int cycles);
    int   base;
    int   sent;
    logic pulse;
    base  = m_count;
    sent  = 0;
    stall = 1'b0;
    for (int i = 0; i < cycles; i++) begin
      fetch_line = AW'($urandom_range(LINES - 1));
      drive_random_record();
      pulse = resolve_valid && (resolve.taken != resolve.predicted);
      if (pulse) begin
        sent++;
      end
      step_cycle();
      check_value("mispredict", 32'(pulse), 32'(mispredict));  // one cycle later
    end
    check_value("mispredict_count", 32'(base + sent), 32'(mispredict_count));
  endtask

  task automatic random_mix(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      stall      = ($urandom_range(3) == 0);  // stalled a quarter of the time
      fetch_line = AW'($urandom_range(LINES - 1));
      drive_random_record();
      step_cycle();
    end
  endtask

  task automatic report_result();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  initial begin
    logic ok;
    int   sat_line;
    int   sat_slot;
    void'($urandom(66));
    errors        = 0;
    checks        = 0;
    rst_at_edge   = 1'b1;
    stall         = 1'b0;
    fetch_line    = '0;
    resolve_valid = 1'b0;
    resolve       = '0;
    model_reset();

    wait_reset(ok);
    if (ok) begin
      zero_after_reset();
      sat_line = int'($urandom_range(LINES - 1));
      sat_slot = int'($urandom_range(bpred_pkg::SLOTS - 1));
      saturation_run(sat_line, sat_slot, 1'b1);
      saturation_run(sat_line, sat_slot, 1'b0);  // mirror direction
      saturation_run(int'($urandom_range(LINES - 1)), 3 - sat_slot, 1'b1);
      stall_hold_run(20);
      mispredict_run(300);
      random_mix(MIX_CYCLES);
    end else begin
      errors++;
      $display("reset did not deassert within %0d cycles", RESET_TIMEOUT);
    end
    report_result();
  end

endmodule

//--- sim.f
design/bpred_pkg.sv
design/counter_bank.sv
design/prediction_buffer.sv
design/branch_resolve_unit.sv
design/bpred_top.sv
tests/clock_gen.sv
tests/bpred_tb.sv

//--- Makefile
# Verilator build and run for the branch predictor testbench

TOP = bpred_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sim.f -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee sim.log
	@grep -q "NO ERRORS" sim.log || (echo "simulation failed"; exit 1)

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sim.f
	verilator --lint-only --top-module bpred_top design/bpred_pkg.sv design/counter_bank.sv \
		design/prediction_buffer.sv design/branch_resolve_unit.sv design/bpred_top.sv

clean:
	rm -rf obj_dir sim.log
